// File: sim.f
src/reset_ctrl_pkg.sv
src/reset_ctrl_if.sv
src/mm_reg_bank.sv
src/reset_pulse_hold.sv
src/reset_channels.sv
src/mm_reset.sv
tb/mm_reset_props.sv
tb/mm_reset_tb.sv

// File: tb/mm_reset_tb.sv
module mm_reset_tb
    import reset_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CYCLES  = 8;
    localparam int PERIOD  = 100;
    localparam int N_LEVEL = 24;
    // Rough length of all tests in clock cycles
    localparam int TOTAL_CYCLES = 6 + 2 * (CYCLES + 12) + (CYCLES + 24)
                                  + (N_LEVEL + 4) * 3 + 4;

    logic                 clk = 1'b0;
    logic                 rst;
    logic [ADDR_BITS-1:0] mm_address;
    logic [N_BYTES-1:0]   mm_byteenable;
    logic                 mm_read;
    logic                 mm_write;
    reg_word_t            mm_writedata;
    reg_word_t            mm_readdata;
    logic                 reset0;
    logic                 reset1;
    logic                 preset0;
    logic                 preset1;

    // Reference state
    reg_word_t level_model [N_PULSE];
    // Model pulse is high after edges from pulse_rise up to, not including, pulse_fall
    time       pulse_rise [N_PULSE];
    time       pulse_fall [N_PULSE];

    mm_reset #(
        .CYCLES (CYCLES)
    ) uut (
        .clk           (clk),
        .rst           (rst),
        .mm_address    (mm_address),
        .mm_byteenable (mm_byteenable),
        .mm_read       (mm_read),
        .mm_write      (mm_write),
        .mm_writedata  (mm_writedata),
        .mm_readdata   (mm_readdata),
        .reset0        (reset0),
        .reset1        (reset1),
        .preset0       (preset0),
        .preset1       (preset1)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic check_value(input string name, input reg_word_t expected,
                               input reg_word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Called on a rising edge, returns on the accepting edge
    task automatic bus_write(input reg_index_t addr, input reg_word_t data,
                             input logic [N_BYTES-1:0] be, output time accepted);
        mm_address    <= addr;
        mm_writedata  <= data;
        mm_byteenable <= be;
        mm_write      <= 1'b1;
        @(posedge clk);
        accepted = $time;
        mm_write <= 1'b0;
    endtask

    task automatic bus_read(input reg_index_t addr, output reg_word_t data,
                            output time accepted, output logic [N_PULSE-1:0] levels);
        mm_address <= addr;
        mm_read    <= 1'b1;
        @(posedge clk);
        accepted = $time;
        mm_read <= 1'b0;
        @(negedge clk);
        data   = mm_readdata;
        levels = {preset1, preset0};
        @(posedge clk);
    endtask

    // A read accepted at edge R sees the output as it was after edge R-1
    function automatic logic pulse_model(input int ch, input time read_at);
        return (read_at > pulse_rise[ch]) && (read_at <= pulse_fall[ch]);
    endfunction

    task automatic trigger(input int ch);
        time at;
        bus_write(ch == 0 ? REG_RESET0 : REG_RESET1, $urandom, N_BYTES'($urandom), at);
        // A trigger before the old fall extends the pulse without a gap
        if (pulse_fall[ch] < at + PERIOD) begin
            pulse_rise[ch] = at + PERIOD;
        end
        pulse_fall[ch] = at + (CYCLES + 1) * PERIOD;
    endtask

    task automatic read_status(input int ch);
        reg_word_t            data;
        time                  at;
        logic [N_PULSE-1:0]   lv;
        bus_read(ch == 0 ? REG_RESET0 : REG_RESET1, data, at, lv);
        check_value($sformatf("mm_readdata (reg %0d)", ch),
                    reg_word_t'(pulse_model(ch, at)), data);
    endtask

    task automatic level_write(input int ch, input reg_word_t data,
                               input logic [N_BYTES-1:0] be);
        reg_word_t mask;
        time       at;
        for (int b = 0; b < N_BYTES; b++) begin
            mask[8*b +: 8] = {8{be[b]}};
        end
        level_model[ch] = (level_model[ch] & ~mask) | (data & mask);
        bus_write(ch == 0 ? REG_PRESET0 : REG_PRESET1, data, be, at);
    endtask

    task automatic level_check(input int ch);
        reg_word_t            data;
        time                  at;
        logic [N_PULSE-1:0]   lv;
        bus_read(ch == 0 ? REG_PRESET0 : REG_PRESET1, data, at, lv);
        check_value($sformatf("mm_readdata (reg %0d)", ch + 2), level_model[ch], data);
        check_value("preset0", reg_word_t'(|level_model[0]), reg_word_t'(lv[0]));
        check_value("preset1", reg_word_t'(|level_model[1]), reg_word_t'(lv[1]));
    endtask

    // Reads every other cycle across the whole pulse
    task automatic test_pulse(input int ch);
        trigger(ch);
        repeat (CYCLES / 2 + 3) begin
            read_status(ch);
        end
        read_status(1 - ch);
    endtask

    task automatic test_retrigger();
        trigger(0);
        wait_cycles(CYCLES / 2);
        trigger(0);
        repeat (CYCLES / 2 + 3) begin
            read_status(0);
        end
    endtask

    task automatic test_levels();
        int        ch;
        reg_word_t data;
        level_write(0, 32'h0000_00a5, 4'b0001);
        level_check(0);
        level_write(0, 32'h0, 4'b1111);
        level_check(0);
        repeat (N_LEVEL) begin
            ch   = $urandom_range(1, 0);
            data = $urandom;
            // Zero words now and then so the level outputs fall again
            if ($urandom_range(3, 0) == 0) begin
                data = '0;
            end
            level_write(ch, data, N_BYTES'($urandom));
            level_check(ch);
        end
        level_write(1, 32'h0, 4'b1111);
        level_check(1);
    endtask

    always @(negedge clk) begin
        if (uut.u_props.fail_count != 0) begin
            $display("A concurrent assertion in mm_reset_props failed");
            abort_run();
        end
    end

    initial begin
        #(2 * TOTAL_CYCLES * PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
        abort_run();
    end

    initial begin
        void'($urandom(55));
        rst           = 1'b1;
        mm_address    = '0;
        mm_byteenable = '0;
        mm_read       = 1'b0;
        mm_write      = 1'b0;
        mm_writedata  = '0;
        for (int ch = 0; ch < N_PULSE; ch++) begin
            level_model[ch] = '0;
            pulse_rise[ch]  = 0;
            pulse_fall[ch]  = 0;
        end

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        test_pulse(0);
        test_pulse(1);
        test_retrigger();
        test_levels();
        wait_cycles(2);

        if (uut.u_props.fail_count != 0) begin
            $display("Assertion failures were counted during the run");
            abort_run();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: tb/mm_reset_props.sv
module mm_reset_props
    import reset_ctrl_pkg::*;
#(
    parameter int CYCLES = 100
) (
    input logic                         clk,
    input logic                         rst,
    input logic [ADDR_BITS-1:0]         mm_address,
    input logic                         mm_read,
    input logic                         mm_write,
    input reg_word_t                    mm_readdata,
    input logic                         reset0,
    input logic                         reset1,
    input logic                         preset0,
    input logic                         preset1,
    input logic [N_PULSE-1:0]           pulse_strobe,
    input logic [N_PULSE-1:0]           level_load,
    input reg_word_t [N_PULSE-1:0]      level_word
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [N_PULSE-1:0] pulse;
    logic [N_PULSE-1:0] levels;

    // Number of failed assertions, watched by the testbench
    int unsigned fail_count = 0;

    assign pulse  = {reset1, reset0};
    assign levels = {preset1, preset0};

    // Everything cleared one edge into reset
    a_reset_state: assert property (@(posedge clk)
        rst |=> (!reset0 && !reset1 && !preset0 && !preset1 && mm_readdata == '0))
    else begin
        fail_count++;
        $error("outputs not cleared by reset");
    end

    a_read_hold: assert property (@(posedge clk) disable iff (rst)
        !mm_read |=> $stable(mm_readdata))
    else begin
        fail_count++;
        $error("mm_readdata changed without a read");
    end

    // Trigger registers only carry bit 0
    a_status_upper: assert property (@(posedge clk) disable iff (rst)
        mm_read && (mm_address == REG_RESET0 || mm_address == REG_RESET1)
        |=> mm_readdata[REG_BITS-1:1] == '0)
    else begin
        fail_count++;
        $error("status read has upper bits set");
    end

    for (genvar ch = 0; ch < N_PULSE; ch++) begin : g_ch
        a_strobe: assert property (@(posedge clk) disable iff (rst)
            mm_write && mm_address == ADDR_BITS'(ch) |=> pulse_strobe[ch])
        else begin
            fail_count++;
            $error("no strobe after trigger write on channel %0d", ch);
        end

        // Every strobe, a retrigger while high included, gives a full pulse with no gap
        a_pulse_hold: assert property (@(posedge clk) disable iff (rst)
            pulse_strobe[ch] |=> pulse[ch] [*CYCLES])
        else begin
            fail_count++;
            $error("pulse on channel %0d shorter than CYCLES", ch);
        end

        a_pulse_end: assert property (@(posedge clk) disable iff (rst)
            pulse_strobe[ch] ##1 (!pulse_strobe[ch]) [*CYCLES] |=> !pulse[ch])
        else begin
            fail_count++;
            $error("pulse on channel %0d longer than CYCLES", ch);
        end

        a_pulse_quiet: assert property (@(posedge clk) disable iff (rst)
            !pulse[ch] && !pulse_strobe[ch] |=> !pulse[ch])
        else begin
            fail_count++;
            $error("pulse on channel %0d rose without a strobe", ch);
        end

        a_level: assert property (@(posedge clk) disable iff (rst)
            !level_load[ch] |-> levels[ch] == (|level_word[ch]))
        else begin
            fail_count++;
            $error("level output %0d does not match stored word", ch);
        end
    end

endmodule

bind mm_reset mm_reset_props #(
    .CYCLES (CYCLES)
) u_props (
    .clk          (clk),
    .rst          (rst),
    .mm_address   (mm_address),
    .mm_read      (mm_read),
    .mm_write     (mm_write),
    .mm_readdata  (mm_readdata),
    .reset0       (reset0),
    .reset1       (reset1),
    .preset0      (preset0),
    .preset1      (preset1),
    .pulse_strobe (ctrl.pulse_strobe),
    .level_load   (ctrl.level_load),
    .level_word   (ctrl.level_word)
);

// File: src/mm_reset.sv
module mm_reset
    import reset_ctrl_pkg::*;
#(
    parameter int CYCLES = 100
) (
    input  logic                 clk,
    input  logic                 rst,

    // Avalon-MM slave, no waitrequest
    input  logic [ADDR_BITS-1:0] mm_address,
    input  logic [N_BYTES-1:0]   mm_byteenable,
    input  logic                 mm_read,
    input  logic                 mm_write,
    input  reg_word_t            mm_writedata,
    output reg_word_t            mm_readdata,

    output logic                 reset0,
    output logic                 reset1,
    output logic                 preset0,
    output logic                 preset1
);

    logic [N_PULSE-1:0] pulse_out;
    logic [N_PULSE-1:0] level_out;

    reset_ctrl_if ctrl ();

    mm_reg_bank u_bank (
        .clk           (clk),
        .rst           (rst),
        .mm_address    (mm_address),
        .mm_byteenable (mm_byteenable),
        .mm_read       (mm_read),
        .mm_write      (mm_write),
        .mm_writedata  (mm_writedata),
        .mm_readdata   (mm_readdata),
        .ctrl          (ctrl.bank)
    );

    reset_channels #(
        .CYCLES (CYCLES)
    ) u_channels (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl.channels),
        .pulse_out (pulse_out),
        .level_out (level_out)
    );

    assign reset0  = pulse_out[0];
    assign reset1  = pulse_out[1];
    assign preset0 = level_out[0];
    assign preset1 = level_out[1];

endmodule

// File: src/reset_channels.sv
module reset_channels
    import reset_ctrl_pkg::*;
#(
    parameter int CYCLES = 100
) (
    input  logic               clk,
    input  logic               rst,

    reset_ctrl_if.channels     ctrl,

    output logic [N_PULSE-1:0] pulse_out,
    output logic [N_PULSE-1:0] level_out
);

    // One stretcher per trigger register
    for (genvar ch = 0; ch < N_PULSE; ch++) begin : g_pulse
        reset_pulse_hold #(
            .CYCLES (CYCLES)
        ) u_hold (
            .clk     (clk),
            .rst     (rst),
            .trigger (ctrl.pulse_strobe[ch]),
            .active  (pulse_out[ch])
        );
    end

    // Status back to the bank for readback
    assign ctrl.pulse_active = pulse_out;

    // Level outputs follow the stored word once it is loaded
    always_ff @(posedge clk) begin
        if (rst) begin
            level_out <= '0;
        end else begin
            for (int ch = 0; ch < N_PULSE; ch++) begin
                if (ctrl.level_load[ch]) begin
                    level_out[ch] <= |ctrl.level_word[ch];
                end
            end
        end
    end

endmodule

// File: src/reset_pulse_hold.sv
module reset_pulse_hold #(
    parameter int CYCLES = 100
) (
    input  logic clk,
    input  logic rst,
    input  logic trigger,
    output logic active
);

    localparam int CNT_BITS = $clog2(CYCLES + 1);

    // Cycles left in the current pulse
    logic [CNT_BITS-1:0] count;

    // A trigger always reloads, so a retrigger extends the pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (trigger) begin
            count <= CNT_BITS'(CYCLES);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // High for exactly CYCLES cycles after the trigger is sampled
    assign active = (count != '0);

endmodule

// File: src/mm_reg_bank.sv
module mm_reg_bank
    import reset_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic [ADDR_BITS-1:0] mm_address,
    input  logic [N_BYTES-1:0]   mm_byteenable,
    input  logic                 mm_read,
    input  logic                 mm_write,
    input  reg_word_t            mm_writedata,
    output reg_word_t            mm_readdata,

    reset_ctrl_if.bank           ctrl
);

    reg_index_t index;
    reg_word_t  read_word;

    // Keep old bytes where the lane is disabled
    function automatic reg_word_t merge_bytes(
        input reg_word_t          old_word,
        input reg_word_t          new_word,
        input logic [N_BYTES-1:0] lanes
    );
        reg_word_t result;
        result = old_word;
        for (int b = 0; b < N_BYTES; b++) begin
            if (lanes[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    assign index = reg_index_t'(mm_address);

    // Trigger registers report the live pulse in bit 0 only
    always_comb begin
        read_word = '0;
        case (index)
            REG_RESET0: begin
                read_word[0] = ctrl.pulse_active[0];
            end
            REG_RESET1: begin
                read_word[0] = ctrl.pulse_active[1];
            end
            REG_PRESET0: begin
                read_word = ctrl.level_word[0];
            end
            REG_PRESET1: begin
                read_word = ctrl.level_word[1];
            end
            default: begin
                read_word = '0;
            end
        endcase
    end

    // Fixed read latency of one cycle, data held between reads
    always_ff @(posedge clk) begin
        if (rst) begin
            mm_readdata <= '0;
        end else if (mm_read) begin
            mm_readdata <= read_word;
        end
    end

    // Write decode: strobes last exactly one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl.pulse_strobe <= '0;
            ctrl.level_load   <= '0;
            ctrl.level_word   <= '0;
        end else begin
            ctrl.pulse_strobe <= '0;
            ctrl.level_load   <= '0;
            if (mm_write) begin
                case (index)
                    REG_RESET0: begin
                        ctrl.pulse_strobe[0] <= 1'b1;
                    end
                    REG_RESET1: begin
                        ctrl.pulse_strobe[1] <= 1'b1;
                    end
                    REG_PRESET0: begin
                        ctrl.level_word[0] <= merge_bytes(ctrl.level_word[0],
                                                          mm_writedata, mm_byteenable);
                        ctrl.level_load[0] <= 1'b1;
                    end
                    REG_PRESET1: begin
                        ctrl.level_word[1] <= merge_bytes(ctrl.level_word[1],
                                                          mm_writedata, mm_byteenable);
                        ctrl.level_load[1] <= 1'b1;
                    end
                    default: begin
                        ctrl.pulse_strobe <= '0;
                    end
                endcase
            end
        end
    end

endmodule

// File: src/reset_ctrl_if.sv
interface reset_ctrl_if
    import reset_ctrl_pkg::*;
();

    // One-cycle strobe per trigger register
    logic [N_PULSE-1:0] pulse_strobe;

    // One-cycle strobe per level register, with the stored words
    logic [N_PULSE-1:0] level_load;
    reg_word_t [N_PULSE-1:0] level_word;

    // Live pulse state, read back through the trigger registers
    logic [N_PULSE-1:0] pulse_active;

    modport bank (
        output pulse_strobe,
        output level_load,
        output level_word,
        input  pulse_active
    );

    modport channels (
        input  pulse_strobe,
        input  level_load,
        input  level_word,
        output pulse_active
    );

endinterface

// File: src/reset_ctrl_pkg.sv
package reset_ctrl_pkg;

    // Register file geometry
    localparam int REG_BITS  = 32;
    localparam int N_REGS    = 4;
    localparam int ADDR_BITS = $clog2(N_REGS);
    localparam int N_BYTES   = REG_BITS / 8;

    // One timed pulse and one level per channel
    localparam int N_PULSE = 2;

    typedef logic [REG_BITS-1:0] reg_word_t;

    // Word addresses as seen on the Avalon-MM port
    typedef enum logic [ADDR_BITS-1:0] {
        REG_RESET0  = 2'd0,
        REG_RESET1  = 2'd1,
        REG_PRESET0 = 2'd2,
        REG_PRESET1 = 2'd3
    } reg_index_t;

endpackage
